// ==== sa_fin.f ====
src/sa_cfg_pkg.sv
src/sa_data_pkg.sv
src/sa_pe.sv
src/sa_channel_out.sv
src/sa_fin.sv
verification/sa_clk_gen.sv
verification/sa_fin_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --timing --assert -Wno-fatal
TOP      := sa_fin_tb
RTL_TOP  := sa_fin
FILELIST := sa_fin.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := Done: errors found

SOURCES  := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/$(TOP): $(SOURCES) $(FILELIST)
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

sim: $(OBJ_DIR)/$(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/sa_fin_tb.sv ====
`timescale 1ns/100ps

module sa_fin_tb
    import sa_cfg_pkg::*, sa_data_pkg::*;
;

    localparam int K_STEPS    = 8;
    localparam int RUN_EDGES  = K_STEPS + ROWS + COLS - 2;   // enabled edges per run
    localparam int MAX_CYCLES = 400;   // five runs with their drains, plus margin

    logic                 clk;
    logic                 cnt_rst;
    logic                 en;
    logic                 acc_clr;
    logic                 mode;
    row_word_u [ROWS-1:0] row_in;
    col_word_t [COLS-1:0] col_in;
    logic                 channel_out_en;
    logic                 channel_out_reset;
    result_row_t          out;
    logic                 out_valid;

    // operands of the current run and the expected sums
    logic [W_WIDTH-1:0] w_op [K_STEPS][ROWS];
    col_word_t          x_op [K_STEPS][COLS];
    result_row_t        exp_rows [ROWS];

    result_row_t expect_row;
    int          expect_idx;
    int          row_cnt;
    int          strobe_cnt = 0;
    int          valid_cnt  = 0;
    int          err_cnt    = 0;
    int          cycle_cnt  = 0;
    int          seed       = 53324;
    logic        ready      = 1'b0;   // one edge of history for $past

    sa_clk_gen u_clk_gen (
        .clk (clk)
    );

    sa_fin sa_fin_i (
        .clk               (clk),
        .cnt_rst           (cnt_rst),
        .en                (en),
        .acc_clr           (acc_clr),
        .mode              (mode),
        .row_in            (row_in),
        .col_in            (col_in),
        .channel_out_en    (channel_out_en),
        .channel_out_reset (channel_out_reset),
        .out               (out),
        .out_valid         (out_valid)
    );

    //////////////////////////////
    // reference model
    //////////////////////////////

    task automatic gen_operands();
        for (int k = 0; k < K_STEPS; k++) begin
            for (int r = 0; r < ROWS; r++) begin
                w_op[k][r] = W_WIDTH'($random(seed));   // upper bits ignored in mode 1
            end
            for (int c = 0; c < COLS; c++) begin
                x_op[k][c] = 16'($random(seed));
            end
        end
    endtask

    task automatic clear_model();
        for (int r = 0; r < ROWS; r++) begin
            exp_rows[r] = '0;
        end
    endtask

    task automatic add_run_to_model(input logic m);
        logic [W_WIDTH-1:0] w;
        col_word_t          x;
        for (int k = 0; k < K_STEPS; k++) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    w = w_op[k][r];
                    x = x_op[k][c];
                    if (m) begin
                        // weight bit 0 feeds a00 and a10, bit 1 feeds a01 and a11
                        if (w[0]) begin
                            exp_rows[r][c].m1.a00 = exp_rows[r][c].m1.a00 + ACC1_WIDTH'(x.x0);
                            exp_rows[r][c].m1.a10 = exp_rows[r][c].m1.a10 + ACC1_WIDTH'(x.x1);
                        end
                        if (w[1]) begin
                            exp_rows[r][c].m1.a01 = exp_rows[r][c].m1.a01 + ACC1_WIDTH'(x.x0);
                            exp_rows[r][c].m1.a11 = exp_rows[r][c].m1.a11 + ACC1_WIDTH'(x.x1);
                        end
                    end else begin
                        exp_rows[r][c].m8.acc0 = exp_rows[r][c].m8.acc0
                            + ACC8_WIDTH'(x.x0) * ACC8_WIDTH'(w);
                        exp_rows[r][c].m8.acc1 = exp_rows[r][c].m8.acc1
                            + ACC8_WIDTH'(x.x1) * ACC8_WIDTH'(w);
                    end
                end
            end
        end
    endtask

    function automatic logic pads_zero(input result_row_t row);
        logic ok;
        ok = 1'b1;
        for (int c = 0; c < COLS; c++) begin
            if (row[c].m8.pad != '0) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // skewed operands for enabled edge e, zero outside the run
    task automatic drive_operands(input int e);
        row_word_u [ROWS-1:0] rw;
        col_word_t [COLS-1:0] cw;
        int                   k;
        rw = '0;
        cw = '0;
        for (int r = 0; r < ROWS; r++) begin
            k = e - r;
            if (k >= 0 && k < K_STEPS) rw[r].w8 = w_op[k][r];
        end
        for (int c = 0; c < COLS; c++) begin
            k = e - c;
            if (k >= 0 && k < K_STEPS) cw[c] = x_op[k][c];
        end
        row_in <= rw;
        col_in <= cw;
    endtask

    // clear, then one run of K_STEPS; gap_at < 0 means no pause
    task automatic run_array(input logic m, input int gap_at, input int gap_len);
        gen_operands();
        clear_model();
        add_run_to_model(m);
        @(posedge clk);
        mode    <= m;
        en      <= 1'b0;
        acc_clr <= 1'b1;
        @(posedge clk);
        acc_clr <= 1'b0;
        for (int e = 0; e < RUN_EDGES; e++) begin
            if (e == gap_at) begin
                en <= 1'b0;   // operands stay as they are
                repeat (gap_len) @(posedge clk);
            end
            en <= 1'b1;
            drive_operands(e);
            @(posedge clk);
        end
        en     <= 1'b0;
        row_in <= '0;
        col_in <= '0;
    endtask

    task automatic drain_rows(input int n);
        for (int i = 0; i < n; i++) begin
            channel_out_en <= 1'b1;   // back to back strobes
            @(posedge clk);
        end
        channel_out_en <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic reset_drain();
        channel_out_reset <= 1'b1;
        @(posedge clk);
        channel_out_reset <= 1'b0;
        @(posedge clk);
    endtask

    task automatic apply_cnt_rst();
        cnt_rst <= 1'b1;
        repeat (3) @(posedge clk);
        cnt_rst <= 1'b0;
        clear_model();   // every accumulator is zero now
        @(posedge clk);
    endtask

    //////////////////////////////
    // expected drain order
    //////////////////////////////

    always @(posedge clk) begin
        ready <= 1'b1;
        if (out_valid) valid_cnt <= valid_cnt + 1;
        if (cnt_rst || channel_out_reset) begin
            row_cnt    <= 0;
            expect_idx <= 0;
            expect_row <= '0;
        end else if (channel_out_en) begin
            expect_row <= exp_rows[row_cnt];
            expect_idx <= row_cnt;
            row_cnt    <= (row_cnt == ROWS-1) ? 0 : row_cnt + 1;   // wraps like the DUT
            strobe_cnt <= strobe_cnt + 1;
        end
    end

    a_drain_row : assert property (@(posedge clk) out_valid |-> out == expect_row)
    else begin
        err_cnt = err_cnt + 1;
        $display("ERROR at %0t: row %0d drained as %h, expected %h",
                 $time, $sampled(expect_idx), $sampled(out), $sampled(expect_row));
    end

    a_valid_after_strobe : assert property (@(posedge clk) out_valid |-> $past(channel_out_en))
    else begin
        err_cnt = err_cnt + 1;
        $display("ERROR at %0t: out_valid without a strobe", $time);
    end

    a_pad_zero : assert property (@(posedge clk) (out_valid && !mode) |-> pads_zero(out))
    else begin
        err_cnt = err_cnt + 1;
        $display("ERROR at %0t: m8 pad bits not zero", $time);
    end

    a_clear_out : assert property (
        @(posedge clk) (ready && $past(cnt_rst || channel_out_reset))
            |-> (out == '0 && !out_valid)
    ) else begin
        err_cnt = err_cnt + 1;
        $display("ERROR at %0t: out %h valid %b after clear",
                 $time, $sampled(out), $sampled(out_valid));
    end

    //////////////////////////////
    // timeout
    //////////////////////////////

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("strobes %0d, errors %0d", strobe_cnt, err_cnt);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        cnt_rst           = 1'b1;
        en                = 1'b0;
        acc_clr           = 1'b0;
        mode              = 1'b0;
        row_in            = '0;
        col_in            = '0;
        channel_out_en    = 1'b0;
        channel_out_reset = 1'b0;
        apply_cnt_rst();

        run_array(1'b0, -1, 0);   // 8x8 mode
        drain_rows(ROWS + 1);     // fifth strobe wraps to row 0

        reset_drain();
        run_array(1'b1, -1, 0);   // 1x8 mode
        drain_rows(ROWS);

        // partial drain, then acc_clr starts a fresh run
        run_array(1'b0, -1, 0);
        drain_rows(2);
        reset_drain();
        run_array(1'b0, -1, 0);
        drain_rows(ROWS + 1);     // pointer left at row 1

        apply_cnt_rst();          // next strobe must drain row 0
        run_array(1'b1, 6, 4);    // en low for four cycles mid-run
        drain_rows(ROWS);

        apply_cnt_rst();
        drain_rows(ROWS);         // all rows zero, starting at row 0

        repeat (2) @(posedge clk);
        if (valid_cnt != strobe_cnt) begin
            err_cnt = err_cnt + 1;
            $display("ERROR at %0t: %0d out_valid pulses for %0d strobes",
                     $time, valid_cnt, strobe_cnt);
        end
        $display("strobes %0d, out_valid pulses %0d, errors %0d",
                 strobe_cnt, valid_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== verification/sa_clk_gen.sv ====
`timescale 1ns/100ps

module sa_clk_gen (
    output logic clk
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

endmodule

// ==== src/sa_fin.sv ====
`timescale 1ns/100ps

module sa_fin
    import sa_cfg_pkg::*, sa_data_pkg::*;
(
    input  logic                 clk,
    input  logic                 cnt_rst,
    input  logic                 en,
    input  logic                 acc_clr,
    input  logic                 mode,
    input  row_word_u [ROWS-1:0] row_in,            // pre-skewed, row 0 lowest
    input  col_word_t [COLS-1:0] col_in,            // pre-skewed, column 0 lowest
    input  logic                 channel_out_en,
    input  logic                 channel_out_reset,
    output result_row_t          out,
    output logic                 out_valid
);

    //////////////////////////////
    // grid links
    //////////////////////////////

    // w_link[r][c] feeds PE(r,c); the last column is the spill-out
    row_word_u w_link [ROWS][COLS+1];
    // x_link[r][c] feeds PE(r,c); the last row is the spill-out
    col_word_t x_link [ROWS+1][COLS];

    // accumulator words gathered by array row
    result_row_t [ROWS-1:0] results;

    //////////////////////////////
    // edge inputs
    //////////////////////////////

    for (genvar r = 0; r < ROWS; r++) begin : g_row_in
        assign w_link[r][0] = row_in[r];
    end

    for (genvar c = 0; c < COLS; c++) begin : g_col_in
        assign x_link[0][c] = col_in[c];
    end

    //////////////////////////////
    // PE grid
    //////////////////////////////

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        for (genvar c = 0; c < COLS; c++) begin : g_col
            sa_pe u_pe (
                .clk     (clk),
                .cnt_rst (cnt_rst),
                .en      (en),
                .acc_clr (acc_clr),
                .mode    (mode),
                .w_in    (w_link[r][c]),
                .x_in    (x_link[r][c]),
                .w_out   (w_link[r][c+1]),   // one edge later per column
                .x_out   (x_link[r+1][c]),   // one edge later per row
                .acc     (results[r][c])
            );
        end
    end

    //////////////////////////////
    // drain stage
    //////////////////////////////

    sa_channel_out u_channel_out (
        .clk               (clk),
        .cnt_rst           (cnt_rst),
        .channel_out_en    (channel_out_en),
        .channel_out_reset (channel_out_reset),
        .results           (results),
        .out               (out),
        .out_valid         (out_valid)
    );

endmodule

// ==== src/sa_channel_out.sv ====
`timescale 1ns/100ps

module sa_channel_out
    import sa_cfg_pkg::*, sa_data_pkg::*;
(
    input  logic                   clk,
    input  logic                   cnt_rst,
    input  logic                   channel_out_en,      // one row per pulse
    input  logic                   channel_out_reset,
    input  result_row_t [ROWS-1:0] results,             // row 0 lowest
    output result_row_t            out,
    output logic                   out_valid
);

    //////////////////////////////
    // row pointer
    //////////////////////////////

    logic [ROW_PTR_WIDTH-1:0] row_ptr;
    logic                     clear;

    assign clear = cnt_rst || channel_out_reset;

    always_ff @(posedge clk) begin
        if (clear) begin
            row_ptr <= '0;
        end else if (channel_out_en) begin
            // wrap back to row 0 after the last row
            if (row_ptr == ROW_PTR_WIDTH'(ROWS-1)) begin
                row_ptr <= '0;
            end else begin
                row_ptr <= row_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////
    // output latch
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (clear) begin
            out <= '0;
        end else if (channel_out_en) begin
            out <= results[row_ptr];   // held until next strobe
        end
    end

    // single cycle pulse after each strobe
    always_ff @(posedge clk) begin
        if (clear) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= channel_out_en;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    a_strobe_vs_reset : assert property (
        @(posedge clk) disable iff (cnt_rst)
        !(channel_out_en && channel_out_reset)
    ) else $error("sa_channel_out: strobe and reset high together");

endmodule

// ==== src/sa_pe.sv ====
`timescale 1ns/100ps

module sa_pe
    import sa_cfg_pkg::*, sa_data_pkg::*;
(
    input  logic      clk,
    input  logic      cnt_rst,
    input  logic      en,
    input  logic      acc_clr,
    input  logic      mode,       // 0: 8x8, 1: 1x8
    input  row_word_u w_in,
    input  col_word_t x_in,
    output row_word_u w_out,      // to the right neighbour
    output col_word_t x_out,      // to the element below
    output acc_word_u acc
);

    //////////////////////////////
    // mode 0 products
    //////////////////////////////

    logic [X_WIDTH+W_WIDTH-1:0] prod0;
    logic [X_WIDTH+W_WIDTH-1:0] prod1;

    assign prod0 = x_in.x0 * w_in.w8;
    assign prod1 = x_in.x1 * w_in.w8;

    //////////////////////////////
    // mode 1 gated activations
    //////////////////////////////

    // a binary weight of 1 passes the activation through
    logic [X_WIDTH-1:0] g00;
    logic [X_WIDTH-1:0] g01;
    logic [X_WIDTH-1:0] g10;
    logic [X_WIDTH-1:0] g11;

    assign g00 = w_in.wb.wb0 ? x_in.x0 : '0;
    assign g10 = w_in.wb.wb0 ? x_in.x1 : '0;
    assign g01 = w_in.wb.wb1 ? x_in.x0 : '0;
    assign g11 = w_in.wb.wb1 ? x_in.x1 : '0;

    //////////////////////////////
    // next accumulator value
    //////////////////////////////

    acc_word_u acc_nxt;

    always_comb begin
        acc_nxt = acc;
        if (mode) begin
            acc_nxt.m1.a00 = acc.m1.a00 + ACC1_WIDTH'(g00);
            acc_nxt.m1.a01 = acc.m1.a01 + ACC1_WIDTH'(g01);
            acc_nxt.m1.a10 = acc.m1.a10 + ACC1_WIDTH'(g10);
            acc_nxt.m1.a11 = acc.m1.a11 + ACC1_WIDTH'(g11);
        end else begin
            acc_nxt.m8.pad  = '0;   // keep upper lanes clean
            acc_nxt.m8.acc0 = acc.m8.acc0 + ACC8_WIDTH'(prod0);
            acc_nxt.m8.acc1 = acc.m8.acc1 + ACC8_WIDTH'(prod1);
        end
    end

    //////////////////////////////
    // registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (cnt_rst || acc_clr) begin
            w_out <= '0;
            x_out <= '0;
            acc   <= '0;
        end else if (en) begin
            w_out <= w_in;     // skew by one cycle per column
            x_out <= x_in;     // skew by one cycle per row
            acc   <= acc_nxt;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // lanes would mix layouts if mode moved inside a run
    a_mode_stable : assert property (
        @(posedge clk) disable iff (cnt_rst)
        en |-> $stable(mode)
    ) else $error("sa_pe: mode changed while enabled");

    // clear wins over en, so both high drops a step
    a_clr_not_en : assert property (
        @(posedge clk) disable iff (cnt_rst)
        !(acc_clr && en)
    ) else $error("sa_pe: acc_clr and en high together");

endmodule

// ==== src/sa_data_pkg.sv ====
package sa_data_pkg;

    import sa_cfg_pkg::*;

    //////////////////////////////
    // operand words
    //////////////////////////////

    // column word, two unsigned activations
    typedef struct packed {
        logic [X_WIDTH-1:0] x1;
        logic [X_WIDTH-1:0] x0;
    } col_word_t;

    // binary weight pair in the low bits of a row word
    typedef struct packed {
        logic [W_WIDTH-3:0] unused;   // ignored in mode 1
        logic               wb1;
        logic               wb0;
    } wb_pair_t;

    // row word, read as w8 in mode 0 and as wb in mode 1
    typedef union packed {
        logic [W_WIDTH-1:0] w8;
        wb_pair_t           wb;
    } row_word_u;

    //////////////////////////////
    // accumulator words
    //////////////////////////////

    // mode 0 layout, pad always zero
    typedef struct packed {
        logic [PE_OUT_WIDTH-2*ACC8_WIDTH-1:0] pad;
        logic [ACC8_WIDTH-1:0]                acc1;   // x1 * w8
        logic [ACC8_WIDTH-1:0]                acc0;   // x0 * w8
    } acc_m8_t;

    // mode 1 layout, lane name is activation then weight index
    typedef struct packed {
        logic [ACC1_WIDTH-1:0] a11;   // x1 * wb1
        logic [ACC1_WIDTH-1:0] a01;   // x0 * wb1
        logic [ACC1_WIDTH-1:0] a10;   // x1 * wb0
        logic [ACC1_WIDTH-1:0] a00;   // x0 * wb0
    } acc_m1_t;

    // one element result, decoded by mode
    typedef union packed {
        acc_m8_t m8;
        acc_m1_t m1;
    } acc_word_u;

    //////////////////////////////
    // drain data
    //////////////////////////////

    // one array row of results, column 0 lowest
    typedef acc_word_u [COLS-1:0] result_row_t;

endpackage

// ==== src/sa_cfg_pkg.sv ====
package sa_cfg_pkg;

    //////////////////////////////
    // array geometry
    //////////////////////////////

    localparam int ROWS = 4;   // weight rows, fed from the left
    localparam int COLS = 4;   // activation columns, fed from the top

    //////////////////////////////
    // operand widths
    //////////////////////////////

    localparam int W_WIDTH = 8;   // row word, one weight or two binary weights
    localparam int X_WIDTH = 8;   // one activation, two per column word

    //////////////////////////////
    // accumulator widths
    //////////////////////////////

    // 16-bit product plus 8 bits headroom
    localparam int ACC8_WIDTH = 24;
    // 8-bit activation plus 8 bits headroom
    localparam int ACC1_WIDTH = 16;

    localparam int PE_OUT_WIDTH = 64;   // four lanes of ACC1_WIDTH

    // drain stage row select
    localparam int ROW_PTR_WIDTH = 2;

endpackage
